//--- verilog/strip_pkg.sv
package strip_pkg;

    //--------------------------------------------------
    // Chain and word geometry

    localparam int n_leds          = 13;
    localparam int w_word          = 32;
    localparam int w_lab_led       = 6;
    localparam int w_seg           = 8;

    localparam int sck_half_cycles = 2;   // lab_clk cycles per strip clock half

    localparam int w_half_cnt      = $clog2(sck_half_cycles + 1);
    localparam int w_word_idx      = $clog2(n_leds + 2);   // Start, LEDs, end
    localparam int w_bit_idx       = $clog2(w_word);
    localparam int w_bit_left      = $clog2(w_word + 1);

    //--------------------------------------------------
    // Typed constants

    localparam logic [w_half_cnt-1:0] half_reload    = w_half_cnt'(sck_half_cycles - 1);
    localparam logic [w_bit_idx-1:0]  last_bit_idx   = w_bit_idx'(w_word - 1);
    localparam logic [w_bit_left-1:0] word_bits      = w_bit_left'(w_word);

    localparam logic [w_word_idx-1:0] start_word_idx = '0;
    localparam logic [w_word_idx-1:0] end_word_idx   = w_word_idx'(n_leds + 1);
    localparam logic [w_word_idx-1:0] last_led_idx   = w_word_idx'(n_leds - 1);

    localparam logic [w_word-1:0]     start_word     = '0;
    localparam logic [w_word-1:0]     end_word       = '1;

    localparam logic [2:0]            led_header     = 3'b111;
    localparam logic [7:0]            color_level    = 8'h11;   // Dim primary color

    //--------------------------------------------------
    // Types

    typedef enum logic [1:0] {
        st_idle,
        st_start,
        st_leds,
        st_finish
    } seq_state_e;

    // SK9822 LED frame, built as fields and shifted as raw bits
    typedef union packed {
        struct packed {
            logic [2:0] header;
            logic [4:0] brightness;
            logic [7:0] blue;
            logic [7:0] green;
            logic [7:0] red;
        } fields;
        logic [w_word-1:0] raw;
    } led_word_u;

endpackage

//--- verilog/strip_bit_timer.sv
module strip_bit_timer (
    input  logic i_lab_clk,
    input  logic rst,
    output logic o_tick
);

    logic [strip_pkg::w_half_cnt-1:0] half_cnt;

    // Free running down counter, one tick per strip clock half period
    always_ff @(posedge i_lab_clk or posedge rst) begin
        if (rst) begin
            half_cnt <= strip_pkg::half_reload;
        end
        else if (half_cnt == '0) begin
            half_cnt <= strip_pkg::half_reload;
        end
        else begin
            half_cnt <= half_cnt - 1'b1;
        end
    end

    assign o_tick = (half_cnt == '0);

endmodule

//--- verilog/strip_sequencer.sv
module strip_sequencer (
    input  logic                            i_lab_clk,
    input  logic                            rst,
    input  logic                            i_tick,
    output logic                            o_snapshot,
    output logic                            o_load,
    output logic                            o_shift,
    output logic                            o_sck_phase,
    output logic                            o_frame_sync,
    output logic [strip_pkg::w_word_idx-1:0] o_word_index
);

    strip_pkg::seq_state_e            state;
    logic [strip_pkg::w_bit_idx-1:0]  bit_cnt;
    logic [strip_pkg::w_word_idx-1:0] word_cnt;
    logic                             phase;     // Strip clock level, 1 is high half

    logic in_word;
    logic last_bit;
    logic low_end;                               // Tick that closes a low half

    assign in_word  = (state != strip_pkg::st_idle);
    assign last_bit = (bit_cnt == strip_pkg::last_bit_idx);
    assign low_end  = i_tick & in_word & ~phase;

    //--------------------------------------------------
    // Bit and word walk
    //
    // A bit is a high half followed by a low half. The word counter
    // moves on in the middle of the last bit, so the next word is
    // already selected when the load tick comes

    always_ff @(posedge i_lab_clk or posedge rst) begin
        if (rst) begin
            state    <= strip_pkg::st_idle;
            bit_cnt  <= '0;
            word_cnt <= strip_pkg::start_word_idx;
            phase    <= 1'b0;
        end
        else if (i_tick) begin
            if (state == strip_pkg::st_idle) begin
                state   <= strip_pkg::st_start;   // Start word loads on this tick
                bit_cnt <= '0;
                phase   <= 1'b1;
            end
            else if (phase) begin
                phase <= 1'b0;
                if (last_bit) begin
                    if (word_cnt == strip_pkg::end_word_idx)
                        word_cnt <= strip_pkg::start_word_idx;
                    else
                        word_cnt <= word_cnt + 1'b1;
                end
            end
            else if (!last_bit) begin
                bit_cnt <= bit_cnt + 1'b1;
                phase   <= 1'b1;
            end
            else if (state == strip_pkg::st_finish) begin
                state   <= strip_pkg::st_idle;    // Refresh done
                bit_cnt <= '0;
            end
            else begin
                bit_cnt <= '0;
                phase   <= 1'b1;
                if (word_cnt == strip_pkg::end_word_idx)
                    state <= strip_pkg::st_finish;
                else
                    state <= strip_pkg::st_leds;
            end
        end
    end

    //--------------------------------------------------
    // Strobes for builder and shifter

    assign o_snapshot   = i_tick & (state == strip_pkg::st_idle);
    assign o_frame_sync = o_snapshot;

    // New word at refresh start and at every word boundary but the last
    assign o_load  = o_snapshot | (low_end & last_bit & (state != strip_pkg::st_finish));

    // The final shift empties the end word so data idles low
    assign o_shift = low_end & (~last_bit | (state == strip_pkg::st_finish));

    assign o_sck_phase  = phase;
    assign o_word_index = word_cnt;

endmodule

//--- verilog/strip_frame_builder.sv
module strip_frame_builder (
    input  logic                             i_lab_clk,
    input  logic                             rst,
    input  logic                             i_snapshot,
    input  logic [strip_pkg::w_lab_led-1:0]  i_lab_led,
    input  logic [strip_pkg::w_seg-1:0]      i_abcdefgh,
    input  logic [strip_pkg::w_word_idx-1:0] i_word_index,
    output strip_pkg::led_word_u             o_word
);

    logic [strip_pkg::w_lab_led-1:0]  lab_led_q;
    logic [strip_pkg::w_seg-1:0]      seg_q;

    logic [strip_pkg::n_leds-1:0]     drive_bits;
    logic [strip_pkg::w_word_idx-1:0] led_idx;
    logic                             drive;

    // Inputs held for the whole refresh
    always_ff @(posedge i_lab_clk or posedge rst) begin
        if (rst) begin
            lab_led_q <= '0;
            seg_q     <= '0;
        end
        else if (i_snapshot) begin
            lab_led_q <= i_lab_led;
            seg_q     <= i_abcdefgh;
        end
    end

    // LED 0 sits in bit 0
    assign drive_bits = {seg_q[4],                        // LED 12
                         seg_q[0], seg_q[1], seg_q[2],    // LEDs 11 to 9
                         seg_q[7], seg_q[6], seg_q[5],    // LEDs 8 to 6
                         lab_led_q};                      // LEDs 5 to 0

    //--------------------------------------------------
    // Word decode

    always_comb begin
        led_idx    = i_word_index - 1'b1;
        drive      = 1'b0;
        o_word.raw = strip_pkg::start_word;

        if (i_word_index == strip_pkg::end_word_idx) begin
            o_word.raw = strip_pkg::end_word;
        end
        else if (i_word_index != strip_pkg::start_word_idx) begin
            drive                    = drive_bits[led_idx];
            o_word.fields.header     = strip_pkg::led_header;
            o_word.fields.brightness = {1'b0, {4{drive}}};   // 15 or 0

            if (led_idx == strip_pkg::last_led_idx) begin
                o_word.fields.blue  = {4'h0, {4{lab_led_q[0]}}};
                o_word.fields.green = {4'h0, {4{lab_led_q[1]}}};
                o_word.fields.red   = {4'h0, {4{lab_led_q[2]}}};
            end
            else begin
                o_word.fields.blue  = (led_idx % 3 == 0) ? strip_pkg::color_level : 8'h00;
                o_word.fields.green = (led_idx % 3 == 1) ? strip_pkg::color_level : 8'h00;
                o_word.fields.red   = (led_idx % 3 == 2) ? strip_pkg::color_level : 8'h00;
            end
        end
    end

endmodule

//--- verilog/strip_shifter.sv
module strip_shifter (
    input  logic                 i_lab_clk,
    input  logic                 rst,
    input  logic                 i_load,
    input  logic                 i_shift,
    input  logic                 i_sck_phase,
    input  strip_pkg::led_word_u i_word,
    output logic                 o_strip_clk,
    output logic                 o_strip_data
);

    logic [strip_pkg::w_word-1:0]     shift_reg;
    logic [strip_pkg::w_bit_left-1:0] bits_left;   // Nonzero while a word is out

    //--------------------------------------------------
    // Serial data, MSB first

    always_ff @(posedge i_lab_clk or posedge rst) begin
        if (rst) begin
            shift_reg <= '0;
        end
        else if (i_load) begin
            shift_reg <= i_word.raw;
        end
        else if (i_shift) begin
            shift_reg <= {shift_reg[strip_pkg::w_word-2:0], 1'b0};   // Zero fill
        end
    end

    assign o_strip_data = shift_reg[strip_pkg::w_word-1];

    //--------------------------------------------------
    // Strip clock

    always_ff @(posedge i_lab_clk or posedge rst) begin
        if (rst) begin
            bits_left   <= '0;
            o_strip_clk <= 1'b0;
        end
        else begin
            if (i_load)
                bits_left <= strip_pkg::word_bits;
            else if (i_shift && bits_left != '0)
                bits_left <= bits_left - 1'b1;

            // One cycle behind the phase, so data moves mid low half
            o_strip_clk <= i_sck_phase & (bits_left != '0);
        end
    end

endmodule

//--- verilog/strip_board_top.sv
module strip_board_top (
    input  logic                            i_lab_clk,
    input  logic                            rst,
    input  logic [strip_pkg::w_lab_led-1:0] i_lab_led,
    input  logic [strip_pkg::w_seg-1:0]     i_abcdefgh,
    output logic                            o_strip_clk,
    output logic                            o_strip_data,
    output logic                            o_frame_sync
);

    logic                             tick;
    logic                             snapshot;
    logic                             load;
    logic                             shift;
    logic                             sck_phase;
    logic [strip_pkg::w_word_idx-1:0] word_index;
    strip_pkg::led_word_u             word;

    //--------------------------------------------------
    // Timing and sequencing

    strip_bit_timer u_bit_timer (
        .i_lab_clk    (i_lab_clk),
        .rst          (rst),
        .o_tick       (tick)
    );

    strip_sequencer u_sequencer (
        .i_lab_clk    (i_lab_clk),
        .rst          (rst),
        .i_tick       (tick),
        .o_snapshot   (snapshot),
        .o_load       (load),
        .o_shift      (shift),
        .o_sck_phase  (sck_phase),
        .o_frame_sync (o_frame_sync),
        .o_word_index (word_index)
    );

    //--------------------------------------------------
    // Data path

    strip_frame_builder u_frame_builder (
        .i_lab_clk    (i_lab_clk),
        .rst          (rst),
        .i_snapshot   (snapshot),
        .i_lab_led    (i_lab_led),
        .i_abcdefgh   (i_abcdefgh),
        .i_word_index (word_index),
        .o_word       (word)
    );

    strip_shifter u_shifter (
        .i_lab_clk    (i_lab_clk),
        .rst          (rst),
        .i_load       (load),
        .i_shift      (shift),
        .i_sck_phase  (sck_phase),
        .i_word       (word),
        .o_strip_clk  (o_strip_clk),   // To SK9822 CI
        .o_strip_data (o_strip_data)   // To SK9822 DI
    );

endmodule

//--- tests/strip_tb.sv
module strip_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int    n_leds            = 13;
    localparam int    words_per_refresh = n_leds + 2;            // Start, LEDs, end
    localparam int    bits_per_refresh  = words_per_refresh * 32;
    localparam int    refresh_cycles    = bits_per_refresh * 4 + 2;   // Plus one idle tick
    localparam int    mid_delay         = refresh_cycles / 2;
    localparam int    max_vec           = 64;
    localparam string trace_path        = "tests/strip_trace.txt";

    logic       lab_clk = 1'b0;
    logic       rst;
    logic [5:0] lab_led;
    logic [7:0] seg;
    logic       strip_clk;
    logic       strip_data;
    logic       frame_sync;

    // Trace contents
    logic        vec_mid  [max_vec];
    logic [5:0]  vec_lab  [max_vec];
    logic [7:0]  vec_seg  [max_vec];
    logic [31:0] exp_word [max_vec][n_leds];
    int          n_vec        = 0;
    logic        trace_loaded = 1'b0;

    // Stream monitor state
    int          sync_cnt   = 0;
    int          since_sync = 0;
    int          edge_cnt   = 0;
    int          cycle_cnt  = 0;
    int          fail_cnt   = 0;
    logic        prev_clk   = 1'b0;
    logic [31:0] shreg      = '0;   // Bits collected from the data line
    logic        run_done   = 1'b0;

    always #10 lab_clk = ~lab_clk;

    strip_board_top u_strip_board_top (
        .i_lab_clk    (lab_clk),
        .rst          (rst),
        .i_lab_led    (lab_led),
        .i_abcdefgh   (seg),
        .o_strip_clk  (strip_clk),
        .o_strip_data (strip_data),
        .o_frame_sync (frame_sync)
    );

    //--------------------------------------------------
    // Helpers

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            fail_cnt++;
            $display("Error at %0d ns: %s, expected %h, got %h",
                     $time, what, expected, actual);
            $display("Regression failed");
            $fatal(1, "Stopped at first mismatch");
        end
    endtask

    task automatic load_trace();
        int    fd;
        int    cnt;
        int    mid_v;
        int    lab_v;
        int    seg_v;
        string line;
        fd = $fopen(trace_path, "r");
        if (fd == 0) begin
            $display("Cannot open trace file %s", trace_path);
            $display("Regression failed");
            $fatal(1, "Missing trace file");
        end
        else begin
            while (!$feof(fd)) begin
                if ($fgets(line, fd) == 0)
                    break;
                if (line.len() < 2 || line.getc(0) == "#")
                    continue;                           // Blank or comment line
                cnt = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                              mid_v, lab_v, seg_v,
                              exp_word[n_vec][0], exp_word[n_vec][1], exp_word[n_vec][2],
                              exp_word[n_vec][3], exp_word[n_vec][4], exp_word[n_vec][5],
                              exp_word[n_vec][6], exp_word[n_vec][7], exp_word[n_vec][8],
                              exp_word[n_vec][9], exp_word[n_vec][10],
                              exp_word[n_vec][11], exp_word[n_vec][12]);
                if (cnt != 16 || n_vec >= max_vec - 1) begin
                    $display("Trace line %0d is unreadable or beyond the vector limit", n_vec);
                    $display("Regression failed");
                    $fatal(1, "Bad trace file");
                end
                else begin
                    vec_mid[n_vec] = (mid_v != 0);
                    vec_lab[n_vec] = lab_v[5:0];
                    vec_seg[n_vec] = seg_v[7:0];
                    n_vec++;
                end
            end
            $fclose(fd);
            trace_loaded = 1'b1;
        end
    endtask

    task automatic apply_vector(input int v);
        lab_led <= vec_lab[v];
        seg     <= vec_seg[v];
    endtask

    task automatic check_word(input int refresh, input int idx, input logic [31:0] got);
        logic [31:0] expected;
        string       what;
        what = $sformatf("refresh %0d word %0d", refresh, idx);

        // All off and all on vectors fix the brightness field
        if (idx > 0 && idx < words_per_refresh - 1) begin
            if (vec_lab[refresh] == 6'h00 && vec_seg[refresh] == 8'h00)
                check_value({what, " brightness"}, 32'd0, 32'(got[28:24]));
            else if (vec_lab[refresh] == 6'h3F && vec_seg[refresh] == 8'hFF)
                check_value({what, " brightness"}, 32'd15, 32'(got[28:24]));
        end

        if (idx == 0)
            expected = 32'h0000_0000;                   // Start frame
        else if (idx == words_per_refresh - 1)
            expected = 32'hFFFF_FFFF;                   // End frame
        else
            expected = exp_word[refresh][idx - 1];
        check_value(what, expected, got);

        if (refresh == n_vec - 1 && idx == words_per_refresh - 1)
            run_done = 1'b1;
    endtask

    //--------------------------------------------------
    // Stimulus

    initial begin : stimulus
        rst     = 1'b1;
        lab_led = '0;
        seg     = '0;
        load_trace();
        @(posedge lab_clk);
        apply_vector(0);                                // Taken by the first snapshot
        @(posedge lab_clk);
        rst <= 1'b0;
        for (int v = 1; v < n_vec; v++) begin
            wait (sync_cnt >= v);
            if (vec_mid[v])
                repeat (mid_delay) @(posedge lab_clk);  // Halfway through a refresh
            else
                @(posedge lab_clk);
            apply_vector(v);
        end
    end

    //--------------------------------------------------
    // Stream monitor on the falling edge

    always @(negedge lab_clk) begin
        if (!rst)
            since_sync++;

        if (frame_sync) begin
            if (sync_cnt > 0) begin
                check_value("cycles between frame syncs",
                            32'(refresh_cycles), 32'(since_sync));
                check_value("strip clock edges per refresh",
                            32'(bits_per_refresh), 32'(edge_cnt));
            end
            sync_cnt++;
            since_sync = 0;
            edge_cnt   = 0;
        end
        else if (sync_cnt == 0) begin
            check_value("strip clock before first sync", 32'd0, 32'(strip_clk));
            check_value("strip data before first sync", 32'd0, 32'(strip_data));
        end

        if (strip_clk && !prev_clk) begin
            if (sync_cnt > 0 && edge_cnt < bits_per_refresh) begin
                shreg = {shreg[30:0], strip_data};     // MSB first
                if (edge_cnt % 32 == 31)
                    check_word(sync_cnt - 1, edge_cnt / 32, shreg);
            end
            edge_cnt++;
        end
        prev_clk = strip_clk;
    end

    //--------------------------------------------------
    // Timeout and result

    initial begin : timeout_guard
        int limit;
        wait (trace_loaded);
        limit = (n_vec + 2) * refresh_cycles;
        while (cycle_cnt < limit) begin
            @(posedge lab_clk);
            cycle_cnt++;
        end
        $display("Timeout after %0d lab_clk cycles without finishing the trace", limit);
        $display("Regression failed");
        $fatal(1, "Timeout");
    end

    initial begin : result
        wait (run_done);
        if (fail_cnt == 0) begin
            $display("Regression passed");
            $finish;
        end
        else begin
            $display("Regression failed");
            $fatal(1, "Checks failed");
        end
    end

endmodule

//--- strip_driver.f
verilog/strip_pkg.sv
verilog/strip_bit_timer.sv
verilog/strip_sequencer.sv
verilog/strip_frame_builder.sv
verilog/strip_shifter.sv
verilog/strip_board_top.sv
tests/strip_tb.sv

//--- Makefile
VERILATOR  ?= verilator
FILELIST   ?= strip_driver.f
TB_TOP     ?= strip_tb
RTL_TOP    ?= strip_board_top
BUILD_DIR  ?= obj_dir
LINT_FLAGS ?= -Wall
SIM_FLAGS  ?= -Wno-fatal
JOBS       ?= 4

# RTL sources in compile order, taken from the file list
RTL_SRCS := $(shell grep '^verilog/' $(FILELIST))

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

build:
	$(VERILATOR) --binary --timing $(SIM_FLAGS) -j $(JOBS) \
		--top-module $(TB_TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# Exit status of the model is the pass or fail result
sim: build
	./$(BUILD_DIR)/V$(TB_TOP)

clean:
	rm -rf $(BUILD_DIR)

//--- tests/strip_trace.txt
# mid lab_led abcdefgh then expected LED words 0 to 12, all hex
# mid 1 applies the vector halfway through the previous refresh
0 00 00 E0110000 E0001100 E0000011 E0110000 E0001100 E0000011 E0110000 E0001100 E0000011 E0110000 E0001100 E0000011 E0000000
0 3F FF EF110000 EF001100 EF000011 EF110000 EF001100 EF000011 EF110000 EF001100 EF000011 EF110000 EF001100 EF000011 EF0F0F0F
0 01 00 EF110000 E0001100 E0000011 E0110000 E0001100 E0000011 E0110000 E0001100 E0000011 E0110000 E0001100 E0000011 E00F0000
0 2A 00 E0110000 EF001100 E0000011 EF110000 E0001100 EF000011 E0110000 E0001100 E0000011 E0110000 E0001100 E0000011 E0000F00
0 15 00 EF110000 E0001100 EF000011 E0110000 EF001100 E0000011 E0110000 E0001100 E0000011 E0110000 E0001100 E0000011 E00F000F
0 00 20 E0110000 E0001100 E0000011 E0110000 E0001100 E0000011 EF110000 E0001100 E0000011 E0110000 E0001100 E0000011 E0000000
0 00 40 E0110000 E0001100 E0000011 E0110000 E0001100 E0000011 E0110000 EF001100 E0000011 E0110000 E0001100 E0000011 E0000000
0 00 80 E0110000 E0001100 E0000011 E0110000 E0001100 E0000011 E0110000 E0001100 EF000011 E0110000 E0001100 E0000011 E0000000
0 00 04 E0110000 E0001100 E0000011 E0110000 E0001100 E0000011 E0110000 E0001100 E0000011 EF110000 E0001100 E0000011 E0000000
0 00 02 E0110000 E0001100 E0000011 E0110000 E0001100 E0000011 E0110000 E0001100 E0000011 E0110000 EF001100 E0000011 E0000000
0 00 01 E0110000 E0001100 E0000011 E0110000 E0001100 E0000011 E0110000 E0001100 E0000011 E0110000 E0001100 EF000011 E0000000
0 00 10 E0110000 E0001100 E0000011 E0110000 E0001100 E0000011 E0110000 E0001100 E0000011 E0110000 E0001100 E0000011 EF000000
0 00 08 E0110000 E0001100 E0000011 E0110000 E0001100 E0000011 E0110000 E0001100 E0000011 E0110000 E0001100 E0000011 E0000000
1 07 5B EF110000 EF001100 EF000011 E0110000 E0001100 E0000011 E0110000 EF001100 E0000011 E0110000 EF001100 EF000011 EF0F0F0F
1 38 A4 E0110000 E0001100 E0000011 EF110000 EF001100 EF000011 EF110000 E0001100 EF000011 EF110000 E0001100 E0000011 E0000000
0 00 00 E0110000 E0001100 E0000011 E0110000 E0001100 E0000011 E0110000 E0001100 E0000011 E0110000 E0001100 E0000011 E0000000
0 3F FF EF110000 EF001100 EF000011 EF110000 EF001100 EF000011 EF110000 EF001100 EF000011 EF110000 EF001100 EF000011 EF0F0F0F
1 00 00 E0110000 E0001100 E0000011 E0110000 E0001100 E0000011 E0110000 E0001100 E0000011 E0110000 E0001100 E0000011 E0000000
